//--- rtl/eth_loop_pkg.sv
package eth_loop_pkg;

  typedef logic [31:0] word_t;     // RAM and register data word.
  typedef logic [3:0]  nibble_t;   // One MII data nibble.
  typedef logic [2:0]  csr_addr_t; // Register index.

  localparam csr_addr_t CSR_CTRL     = 3'd0; // Bit 0 starts a frame.
  localparam csr_addr_t CSR_STATUS   = 3'd1; // Busy in bit 0, done in bit 1.
  localparam csr_addr_t CSR_TX_BASE  = 3'd2; // First word of the transmit image.
  localparam csr_addr_t CSR_RX_BASE  = 3'd3; // First word of the receive region.
  localparam csr_addr_t CSR_LEN      = 3'd4; // Frame length in words.
  localparam csr_addr_t CSR_RX_COUNT = 3'd5; // Words written by the last frame.

  localparam int NIBBLES_PER_WORD = 8; // 32 bits over a 4-bit MII.

  // Transmit fetch machine. SHIFT means a fetched word waits for the shifter.
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    WAIT,
    SHIFT
  } tx_state_e;

endpackage

//--- rtl/word_ram.sv
module word_ram #(
  parameter int ADDR_W = 8
) (
  input  logic                clk_i,
  input  logic                en_i,
  input  logic                we_i,
  input  logic [ADDR_W-1:0]   addr_i,
  input  eth_loop_pkg::word_t wdata_i,
  output eth_loop_pkg::word_t rdata_o
);

  localparam int DEPTH = 2 ** ADDR_W;

  eth_loop_pkg::word_t mem_q [DEPTH]; // Shared frame storage.

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end
      rdata_o <= mem_q[addr_i]; // Old data on a write, one cycle latency.
    end
  end

endmodule

//--- rtl/mem_arbiter.sv
module mem_arbiter #(
  parameter int ADDR_W = 8
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                rx_req_i,
  input  logic                rx_we_i,
  input  logic [ADDR_W-1:0]   rx_addr_i,
  input  eth_loop_pkg::word_t rx_wdata_i,
  output logic                rx_gnt_o,
  input  logic                tx_req_i,
  input  logic [ADDR_W-1:0]   tx_addr_i,
  output logic                tx_gnt_o,
  output logic                tx_rvalid_o,
  output eth_loop_pkg::word_t tx_rdata_o,
  input  logic                host_req_i,
  input  logic                host_we_i,
  input  logic [ADDR_W-1:0]   host_addr_i,
  input  eth_loop_pkg::word_t host_wdata_i,
  output logic                host_gnt_o,
  output logic                host_rvalid_o,
  output eth_loop_pkg::word_t host_rdata_o,
  output logic                ram_en_o,
  output logic                ram_we_o,
  output logic [ADDR_W-1:0]   ram_addr_o,
  output eth_loop_pkg::word_t ram_wdata_o,
  input  eth_loop_pkg::word_t ram_rdata_i
);

  logic tx_rd_q;   // Read of last cycle belongs to tx.
  logic host_rd_q; // Read of last cycle belongs to host.

  // Fixed priority, rx first since its nibble stream cannot stall.
  assign rx_gnt_o   = rx_req_i;
  assign tx_gnt_o   = tx_req_i && !rx_req_i;
  assign host_gnt_o = host_req_i && !rx_req_i && !tx_req_i;

  assign ram_en_o = rx_req_i || tx_req_i || host_req_i; // RAM takes every cycle.

  always_comb begin
    if (rx_req_i) begin
      ram_we_o    = rx_we_i;
      ram_addr_o  = rx_addr_i;
      ram_wdata_o = rx_wdata_i;
    end else if (tx_req_i) begin
      ram_we_o    = 1'b0;
      ram_addr_o  = tx_addr_i;
      ram_wdata_o = '0;
    end else begin
      ram_we_o    = host_we_i && host_req_i;
      ram_addr_o  = host_addr_i;
      ram_wdata_o = host_wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_rd_q   <= 1'b0;
      host_rd_q <= 1'b0;
    end else begin
      tx_rd_q   <= tx_gnt_o;
      host_rd_q <= host_gnt_o && !host_we_i; // Writes return nothing.
    end
  end

  assign tx_rvalid_o   = tx_rd_q;
  assign tx_rdata_o    = tx_rd_q ? ram_rdata_i : '0;
  assign host_rvalid_o = host_rd_q;
  assign host_rdata_o  = host_rd_q ? ram_rdata_i : '0;

endmodule

//--- rtl/eth_csr.sv
module eth_csr #(
  parameter int ADDR_W = 8
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    csr_valid_i,
  input  logic                    csr_we_i,
  input  eth_loop_pkg::csr_addr_t csr_addr_i,
  input  eth_loop_pkg::word_t     csr_wdata_i,
  output eth_loop_pkg::word_t     csr_rdata_o,
  output logic                    csr_rvalid_o,
  output logic                    tx_start_o,
  output logic [ADDR_W-1:0]       tx_base_o,
  output logic [ADDR_W-1:0]       rx_base_o,
  output logic [ADDR_W-1:0]       frame_len_o,
  input  logic                    frame_end_i,
  input  logic [ADDR_W-1:0]       rx_count_i,
  output logic                    done_o
);

  logic                busy_q;     // Frame in flight.
  logic                done_q;     // Sticky, cleared by a STATUS write.
  logic [ADDR_W-1:0]   rx_count_q; // Latched at frame end.
  logic                wr_en;
  logic                rd_en;
  logic                start_acc;
  eth_loop_pkg::word_t rdata_d;

  assign wr_en = csr_valid_i && csr_we_i;
  assign rd_en = csr_valid_i && !csr_we_i;
  assign start_acc = wr_en && (csr_addr_i == eth_loop_pkg::CSR_CTRL) &&
                     csr_wdata_i[0] && !busy_q; // Start ignored while busy.

  always_comb begin
    case (csr_addr_i)
      eth_loop_pkg::CSR_STATUS:   rdata_d = eth_loop_pkg::word_t'({done_q, busy_q});
      eth_loop_pkg::CSR_TX_BASE:  rdata_d = eth_loop_pkg::word_t'(tx_base_o);
      eth_loop_pkg::CSR_RX_BASE:  rdata_d = eth_loop_pkg::word_t'(rx_base_o);
      eth_loop_pkg::CSR_LEN:      rdata_d = eth_loop_pkg::word_t'(frame_len_o);
      eth_loop_pkg::CSR_RX_COUNT: rdata_d = eth_loop_pkg::word_t'(rx_count_q);
      default:                    rdata_d = '0; // CTRL reads as zero.
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      csr_rdata_o  <= '0;
      csr_rvalid_o <= 1'b0;
      tx_start_o   <= 1'b0;
      tx_base_o    <= '0;
      rx_base_o    <= '0;
      frame_len_o  <= '0;
      rx_count_q   <= '0;
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
      done_o       <= 1'b0;
    end else begin
      tx_start_o   <= 1'b0;  // Pulses.
      done_o       <= 1'b0;
      csr_rvalid_o <= rd_en; // Read data one cycle later.
      if (rd_en) csr_rdata_o <= rdata_d;
      if (wr_en) begin
        case (csr_addr_i)
          eth_loop_pkg::CSR_STATUS:  done_q      <= 1'b0;
          eth_loop_pkg::CSR_TX_BASE: tx_base_o   <= csr_wdata_i[ADDR_W-1:0];
          eth_loop_pkg::CSR_RX_BASE: rx_base_o   <= csr_wdata_i[ADDR_W-1:0];
          eth_loop_pkg::CSR_LEN:     frame_len_o <= csr_wdata_i[ADDR_W-1:0];
          default: ;
        endcase
      end
      if (start_acc) begin
        if (frame_len_o == '0) begin // Empty frame completes at once.
          done_q     <= 1'b1;
          done_o     <= 1'b1;
          rx_count_q <= '0;
        end else begin
          busy_q     <= 1'b1;
          tx_start_o <= 1'b1;
        end
      end
      if (frame_end_i) begin // Receive side finished its last write.
        busy_q     <= 1'b0;
        done_q     <= 1'b1;
        done_o     <= 1'b1;
        rx_count_q <= rx_count_i;
      end
    end
  end

endmodule

//--- rtl/eth_dma_tx.sv
module eth_dma_tx #(
  parameter int ADDR_W  = 8,
  parameter int MII_DIV = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  start_i,
  input  logic [ADDR_W-1:0]     base_i,
  input  logic [ADDR_W-1:0]     len_i,
  output logic                  mem_req_o,
  output logic [ADDR_W-1:0]     mem_addr_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  eth_loop_pkg::word_t   mem_rdata_i,
  output eth_loop_pkg::nibble_t mii_d_o,
  output logic                  mii_dv_o,
  output logic                  mii_stb_o
);

  localparam int DIV_W    = $clog2(MII_DIV);
  localparam int NIB_LAST = eth_loop_pkg::NIBBLES_PER_WORD - 1;

  logic [DIV_W-1:0]        div_cnt_q;   // Free-running nibble divider.
  eth_loop_pkg::tx_state_e state_q;
  logic [ADDR_W-1:0]       base_q;
  logic [ADDR_W-1:0]       len_q;
  logic [ADDR_W-1:0]       fetch_idx_q; // Next word to fetch.
  eth_loop_pkg::word_t     buf_q;       // Prefetched word.
  eth_loop_pkg::word_t     sh_word_q;   // Word on the wire.
  logic [2:0]              nib_left_q;  // Nibbles still to send.
  logic                    load;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      div_cnt_q <= '0;
    end else if (div_cnt_q == DIV_W'(MII_DIV - 1)) begin
      div_cnt_q <= '0;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  assign mii_stb_o = (div_cnt_q == DIV_W'(MII_DIV - 1)); // One cycle in MII_DIV.

  // Shifter takes the buffer once the current word is out.
  assign load = mii_stb_o && (nib_left_q == '0) && (state_q == eth_loop_pkg::SHIFT);

  assign mem_req_o  = (state_q == eth_loop_pkg::FETCH);
  assign mem_addr_o = base_q + fetch_idx_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= eth_loop_pkg::IDLE;
      base_q      <= '0;
      len_q       <= '0;
      fetch_idx_q <= '0;
    end else begin
      case (state_q)
        eth_loop_pkg::IDLE: begin
          if (start_i && (len_i != '0)) begin
            base_q      <= base_i;
            len_q       <= len_i;
            fetch_idx_q <= '0;
            state_q     <= eth_loop_pkg::FETCH;
          end
        end
        eth_loop_pkg::FETCH: begin
          if (mem_gnt_i) begin // Request held until granted.
            fetch_idx_q <= fetch_idx_q + 1'b1;
            state_q     <= eth_loop_pkg::WAIT;
          end
        end
        eth_loop_pkg::WAIT: begin
          if (mem_rvalid_i) state_q <= eth_loop_pkg::SHIFT;
        end
        eth_loop_pkg::SHIFT: begin
          if (load) begin // Buffer free, fetch ahead or finish.
            state_q <= (fetch_idx_q == len_q) ? eth_loop_pkg::IDLE : eth_loop_pkg::FETCH;
          end
        end
        default: state_q <= eth_loop_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == eth_loop_pkg::WAIT) && mem_rvalid_i) buf_q <= mem_rdata_i;
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      sh_word_q <= buf_q >> 4;
    end else if (mii_stb_o && (nib_left_q != '0)) begin
      sh_word_q <= sh_word_q >> 4;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      nib_left_q <= '0;
      mii_d_o    <= '0;
      mii_dv_o   <= 1'b0;
    end else if (mii_stb_o) begin
      if (nib_left_q != '0) begin // Mid-word, next nibble.
        mii_d_o    <= sh_word_q[3:0];
        nib_left_q <= nib_left_q - 1'b1;
        mii_dv_o   <= 1'b1;
      end else if (load) begin // Low nibble of a new word.
        mii_d_o    <= buf_q[3:0];
        nib_left_q <= 3'(NIB_LAST);
        mii_dv_o   <= 1'b1;
      end else begin
        mii_dv_o   <= 1'b0; // Frame over.
      end
    end
  end

endmodule

//--- rtl/eth_dma_rx.sv
module eth_dma_rx #(
  parameter int ADDR_W = 8
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [ADDR_W-1:0]     base_i,
  input  eth_loop_pkg::nibble_t mii_d_i,
  input  logic                  mii_dv_i,
  input  logic                  mii_stb_i,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [ADDR_W-1:0]     mem_addr_o,
  output eth_loop_pkg::word_t   mem_wdata_o,
  input  logic                  mem_gnt_i,
  output logic                  frame_end_o,
  output logic [ADDR_W-1:0]     count_o
);

  localparam int NIB_LAST = eth_loop_pkg::NIBBLES_PER_WORD - 1;

  eth_loop_pkg::word_t word_q;     // Assembly register, fills from the top.
  eth_loop_pkg::word_t word_next;
  logic [2:0]          nib_cnt_q;
  logic [ADDR_W-1:0]   word_cnt_q; // Words of this frame.
  logic                in_frame_q;
  logic                end_pend_q; // Frame over, last write may be pending.
  logic                wr_req_q;
  logic                nib_take;
  logic                word_done;

  assign nib_take  = mii_stb_i && mii_dv_i;
  assign word_next = {mii_d_i, word_q[31:4]}; // First nibble ends up lowest.
  assign word_done = nib_take && (nib_cnt_q == 3'(NIB_LAST));

  assign mem_req_o = wr_req_q;
  assign mem_we_o  = wr_req_q; // Write-only requester.

  always_ff @(posedge clk_i) begin
    if (nib_take) word_q <= word_next;
  end

  always_ff @(posedge clk_i) begin
    if (word_done) begin
      mem_wdata_o <= word_next;
      mem_addr_o  <= base_i + word_cnt_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      nib_cnt_q   <= '0;
      word_cnt_q  <= '0;
      in_frame_q  <= 1'b0;
      end_pend_q  <= 1'b0;
      wr_req_q    <= 1'b0;
      frame_end_o <= 1'b0;
      count_o     <= '0;
    end else begin
      frame_end_o <= 1'b0;
      if (mem_gnt_i) wr_req_q <= 1'b0;
      if (nib_take) begin
        nib_cnt_q  <= nib_cnt_q + 1'b1; // Wraps every word.
        in_frame_q <= 1'b1;
      end
      if (word_done) begin
        wr_req_q   <= 1'b1;
        word_cnt_q <= word_cnt_q + 1'b1;
      end
      if (mii_stb_i && !mii_dv_i && in_frame_q) begin // First idle strobe.
        in_frame_q <= 1'b0;
        end_pend_q <= 1'b1;
      end
      if (end_pend_q && !wr_req_q) begin // Last write granted.
        end_pend_q  <= 1'b0;
        frame_end_o <= 1'b1;
        count_o     <= word_cnt_q;
        word_cnt_q  <= '0;
        nib_cnt_q   <= '0;
      end
    end
  end

endmodule

//--- rtl/eth_loop_top.sv
module eth_loop_top #(
  parameter int ADDR_W  = 8,
  parameter int MII_DIV = 4
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    csr_valid_i,
  input  logic                    csr_we_i,
  input  eth_loop_pkg::csr_addr_t csr_addr_i,
  input  eth_loop_pkg::word_t     csr_wdata_i,
  output eth_loop_pkg::word_t     csr_rdata_o,
  output logic                    csr_rvalid_o,
  output logic                    done_o,
  input  logic                    mem_req_i,
  input  logic                    mem_we_i,
  input  logic [ADDR_W-1:0]       mem_addr_i,
  input  eth_loop_pkg::word_t     mem_wdata_i,
  output logic                    mem_gnt_o,
  output logic                    mem_rvalid_o,
  output eth_loop_pkg::word_t     mem_rdata_o
);

  logic                  tx_start;
  logic [ADDR_W-1:0]     tx_base;
  logic [ADDR_W-1:0]     rx_base;
  logic [ADDR_W-1:0]     frame_len;
  logic                  frame_end;
  logic [ADDR_W-1:0]     rx_count;
  eth_loop_pkg::nibble_t mii_d;    // Loopback, tx straight to rx.
  logic                  mii_dv;
  logic                  mii_stb;
  logic                  tx_req;
  logic [ADDR_W-1:0]     tx_addr;
  logic                  tx_gnt;
  logic                  tx_rvalid;
  eth_loop_pkg::word_t   tx_rdata;
  logic                  rx_req;
  logic                  rx_we;
  logic [ADDR_W-1:0]     rx_addr;
  eth_loop_pkg::word_t   rx_wdata;
  logic                  rx_gnt;
  logic                  ram_en;
  logic                  ram_we;
  logic [ADDR_W-1:0]     ram_addr;
  eth_loop_pkg::word_t   ram_wdata;
  eth_loop_pkg::word_t   ram_rdata;

  eth_csr #(.ADDR_W(ADDR_W)) csr_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .csr_valid_i(csr_valid_i), .csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i),
    .csr_wdata_i(csr_wdata_i), .csr_rdata_o(csr_rdata_o), .csr_rvalid_o(csr_rvalid_o),
    .tx_start_o(tx_start), .tx_base_o(tx_base), .rx_base_o(rx_base),
    .frame_len_o(frame_len), .frame_end_i(frame_end), .rx_count_i(rx_count),
    .done_o(done_o)
  );

  eth_dma_tx #(.ADDR_W(ADDR_W), .MII_DIV(MII_DIV)) dma_tx_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .start_i(tx_start), .base_i(tx_base), .len_i(frame_len),
    .mem_req_o(tx_req), .mem_addr_o(tx_addr), .mem_gnt_i(tx_gnt),
    .mem_rvalid_i(tx_rvalid), .mem_rdata_i(tx_rdata),
    .mii_d_o(mii_d), .mii_dv_o(mii_dv), .mii_stb_o(mii_stb)
  );

  eth_dma_rx #(.ADDR_W(ADDR_W)) dma_rx_i (
    .clk_i(clk_i), .reset_i(reset_i), .base_i(rx_base),
    .mii_d_i(mii_d), .mii_dv_i(mii_dv), .mii_stb_i(mii_stb),
    .mem_req_o(rx_req), .mem_we_o(rx_we), .mem_addr_o(rx_addr),
    .mem_wdata_o(rx_wdata), .mem_gnt_i(rx_gnt),
    .frame_end_o(frame_end), .count_o(rx_count)
  );

  mem_arbiter #(.ADDR_W(ADDR_W)) arb_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .rx_req_i(rx_req), .rx_we_i(rx_we), .rx_addr_i(rx_addr),
    .rx_wdata_i(rx_wdata), .rx_gnt_o(rx_gnt),
    .tx_req_i(tx_req), .tx_addr_i(tx_addr), .tx_gnt_o(tx_gnt),
    .tx_rvalid_o(tx_rvalid), .tx_rdata_o(tx_rdata),
    .host_req_i(mem_req_i), .host_we_i(mem_we_i), .host_addr_i(mem_addr_i),
    .host_wdata_i(mem_wdata_i), .host_gnt_o(mem_gnt_o),
    .host_rvalid_o(mem_rvalid_o), .host_rdata_o(mem_rdata_o),
    .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_addr_o(ram_addr),
    .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata)
  );

  word_ram #(.ADDR_W(ADDR_W)) ram_i (
    .clk_i(clk_i), .en_i(ram_en), .we_i(ram_we), .addr_i(ram_addr),
    .wdata_i(ram_wdata), .rdata_o(ram_rdata)
  );

endmodule

//--- tb/eth_loop_checker.sv
module eth_loop_checker #(
  parameter int ADDR_W = 8
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [2:0]              gnt_i,      // Grants of all requesters.
  input  logic                    req_i,      // One held request.
  input  logic                    req_gnt_i,
  input  logic [ADDR_W-1:0]       req_addr_i,
  input  logic                    mii_dv_i,
  input  logic [2:0]              nib_left_i  // Nibbles still due in this word.
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_gnt = 0;
  int fail_hold = 0;
  int fail_dv = 0;
  int fail_count;

  assign fail_count = fail_gnt + fail_hold + fail_dv;

  a_one_grant: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_i))
    else begin
      fail_gnt++;
      $error("more than one grant in a cycle");
    end

  a_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i && !req_gnt_i |=> req_i && $stable(req_addr_i))
    else begin
      fail_hold++;
      $error("request dropped or changed before its grant");
    end

  // Valid may only fall on a word boundary.
  a_dv_word: assert property (@(posedge clk_i) disable iff (reset_i)
    mii_dv_i && (nib_left_i != '0) |=> mii_dv_i)
    else begin
      fail_dv++;
      $error("mii_dv dropped in the middle of a word");
    end

endmodule

//--- tb/eth_loop_monitor.sv
module eth_loop_monitor (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                csr_valid_i,
  input  logic                csr_we_i,
  input  logic                csr_rvalid_i,
  input  eth_loop_pkg::word_t csr_rdata_i,
  input  logic                mem_req_i,
  input  logic                mem_we_i,
  input  logic                mem_gnt_i,
  input  logic                mem_rvalid_i,
  input  eth_loop_pkg::word_t mem_rdata_i,
  input  logic                done_i,
  input  logic                csr_exp_push_i, // Expected read data from the stimulus.
  input  eth_loop_pkg::word_t csr_exp_i,
  input  logic                mem_exp_push_i,
  input  eth_loop_pkg::word_t mem_exp_i,
  input  logic                done_exp_i,     // One per accepted start.
  input  logic                final_check_i,
  output int                  err_count_o
);
  timeunit 1ns;
  timeprecision 100ps;

  eth_loop_pkg::word_t csr_q [$]; // Outstanding register reads.
  eth_loop_pkg::word_t mem_q [$]; // Outstanding host reads.
  eth_loop_pkg::word_t exp;
  logic                csr_rd_q = 1'b0;
  logic                mem_rd_q = 1'b0;
  int                  done_pend = 0;
  int                  err_cnt = 0;

  assign err_count_o = err_cnt;

  // Sampled mid-cycle, all outputs settled.
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (csr_rvalid_i != csr_rd_q) begin // Exactly one cycle after the strobe.
        $display("error csr_rvalid_o: got %h expected %h", csr_rvalid_i, csr_rd_q);
        err_cnt++;
      end
      if (csr_rvalid_i && (csr_q.size() != 0)) begin
        exp = csr_q.pop_front();
        if (csr_rdata_i != exp) begin
          $display("error csr_rdata_o: got %h expected %h", csr_rdata_i, exp);
          err_cnt++;
        end
      end
      if (mem_rvalid_i != mem_rd_q) begin // One cycle after the read grant.
        $display("error mem_rvalid_o: got %h expected %h", mem_rvalid_i, mem_rd_q);
        err_cnt++;
      end
      if (mem_rvalid_i && (mem_q.size() != 0)) begin
        exp = mem_q.pop_front();
        if (mem_rdata_i != exp) begin
          $display("error mem_rdata_o: got %h expected %h", mem_rdata_i, exp);
          err_cnt++;
        end
      end
      if (done_i) begin
        if (done_pend == 0) begin
          $display("done_o pulsed with no accepted start pending");
          err_cnt++;
        end else begin
          done_pend--;
        end
      end
      if (done_exp_i) done_pend++;
      if (csr_exp_push_i) csr_q.push_back(csr_exp_i);
      if (mem_exp_push_i) mem_q.push_back(mem_exp_i);
      csr_rd_q = csr_valid_i && !csr_we_i;
      mem_rd_q = mem_req_i && mem_gnt_i && !mem_we_i;
      if (final_check_i && ((csr_q.size() + mem_q.size() + done_pend) != 0)) begin
        $display("run ended with %0d register reads, %0d host reads and %0d done pulses missing",
                 csr_q.size(), mem_q.size(), done_pend);
        err_cnt++;
      end
    end
  end

endmodule

//--- tb/tb_eth_loop.sv
module tb_eth_loop;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_W       = 8;
  localparam int MII_DIV      = 4;
  localparam int MAX_WORDS    = 16;
  localparam int LEN_A        = 6;
  localparam int LEN_B        = 0;
  localparam int LEN_C        = 9;
  localparam int FRAME_MARGIN = 300; // Setup, read-back and host traffic per frame.
  localparam int TIMEOUT_CYCLES = (LEN_A + LEN_B + LEN_C) * eth_loop_pkg::NIBBLES_PER_WORD *
                                  MII_DIV + 3 * FRAME_MARGIN;
  localparam int EXT_BASE     = 'hC0; // Host-only words, outside all frame regions.
  localparam int EXT_WORDS    = 8;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    csr_valid;
  logic                    csr_we;
  eth_loop_pkg::csr_addr_t csr_addr;
  eth_loop_pkg::word_t     csr_wdata;
  eth_loop_pkg::word_t     csr_rdata;
  logic                    csr_rvalid;
  logic                    done;
  logic                    mem_req;
  logic                    mem_we;
  logic [ADDR_W-1:0]       mem_addr;
  eth_loop_pkg::word_t     mem_wdata;
  logic                    mem_gnt;
  logic                    mem_rvalid;
  eth_loop_pkg::word_t     mem_rdata;
  logic                    csr_exp_push;
  eth_loop_pkg::word_t     csr_exp;
  logic                    mem_exp_push;
  eth_loop_pkg::word_t     mem_exp;
  logic                    done_exp;
  logic                    final_check;
  int                      mon_errors;
  int                      assert_errors;
  int                      seed = 92;
  int                      cycle_cnt = 0;
  eth_loop_pkg::word_t     img [MAX_WORDS];       // Transmit image of the current frame.
  eth_loop_pkg::word_t     exp_rx [MAX_WORDS];
  eth_loop_pkg::word_t     ext_words [EXT_WORDS];

  eth_loop_top #(.ADDR_W(ADDR_W), .MII_DIV(MII_DIV)) dut_i (
    .clk_i(clk), .reset_i(reset),
    .csr_valid_i(csr_valid), .csr_we_i(csr_we), .csr_addr_i(csr_addr),
    .csr_wdata_i(csr_wdata), .csr_rdata_o(csr_rdata), .csr_rvalid_o(csr_rvalid),
    .done_o(done), .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
    .mem_wdata_i(mem_wdata), .mem_gnt_o(mem_gnt), .mem_rvalid_o(mem_rvalid),
    .mem_rdata_o(mem_rdata)
  );

  eth_loop_monitor monitor_i (
    .clk_i(clk), .reset_i(reset), .csr_valid_i(csr_valid), .csr_we_i(csr_we),
    .csr_rvalid_i(csr_rvalid), .csr_rdata_i(csr_rdata), .mem_req_i(mem_req),
    .mem_we_i(mem_we), .mem_gnt_i(mem_gnt), .mem_rvalid_i(mem_rvalid),
    .mem_rdata_i(mem_rdata), .done_i(done), .csr_exp_push_i(csr_exp_push),
    .csr_exp_i(csr_exp), .mem_exp_push_i(mem_exp_push), .mem_exp_i(mem_exp),
    .done_exp_i(done_exp), .final_check_i(final_check), .err_count_o(mon_errors)
  );

  bind mem_arbiter eth_loop_checker #(.ADDR_W(ADDR_W)) arb_chk_i (
    .clk_i(clk_i), .reset_i(reset_i), .gnt_i({host_gnt_o, tx_gnt_o, rx_gnt_o}),
    .req_i(host_req_i), .req_gnt_i(host_gnt_o), .req_addr_i(host_addr_i),
    .mii_dv_i(1'b0), .nib_left_i(3'd0)
  );

  bind eth_dma_tx eth_loop_checker #(.ADDR_W(ADDR_W)) tx_chk_i (
    .clk_i(clk_i), .reset_i(reset_i), .gnt_i({2'b00, mem_gnt_i}),
    .req_i(mem_req_o), .req_gnt_i(mem_gnt_i), .req_addr_i(mem_addr_o),
    .mii_dv_i(mii_dv_o), .nib_left_i(nib_left_q)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // Loopback copies the image word for word.
  function automatic int ref_loopback(input eth_loop_pkg::word_t src [MAX_WORDS], input int len,
                                      output eth_loop_pkg::word_t dst [MAX_WORDS]);
    for (int i = 0; i < MAX_WORDS; i++) begin
      dst[i] = (i < len) ? src[i] : '0;
    end
    return len;
  endfunction

  task csr_write(input eth_loop_pkg::csr_addr_t addr, input eth_loop_pkg::word_t data);
    csr_valid = 1'b1;
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(posedge clk);
    #1;
    csr_valid = 1'b0;
    csr_we    = 1'b0;
  endtask

  task csr_read(input eth_loop_pkg::csr_addr_t addr, input eth_loop_pkg::word_t exp);
    csr_valid    = 1'b1;
    csr_we       = 1'b0;
    csr_addr     = addr;
    csr_exp_push = 1'b1;
    csr_exp      = exp;
    @(posedge clk);
    #1;
    csr_valid    = 1'b0;
    csr_exp_push = 1'b0;
  endtask

  task wait_grant();
    logic granted;
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk);
      granted = mem_gnt;     // DMA traffic may hold it off.
      @(posedge clk);
      #1;
      mem_exp_push = 1'b0;
    end
    mem_req = 1'b0;
    mem_we  = 1'b0;
  endtask

  task mem_write(input logic [ADDR_W-1:0] addr, input eth_loop_pkg::word_t data);
    mem_req   = 1'b1;
    mem_we    = 1'b1;
    mem_addr  = addr;
    mem_wdata = data;
    wait_grant();
  endtask

  task mem_read(input logic [ADDR_W-1:0] addr, input eth_loop_pkg::word_t exp);
    mem_req      = 1'b1;
    mem_we       = 1'b0;
    mem_addr     = addr;
    mem_exp_push = 1'b1;
    mem_exp      = exp;
    wait_grant();
  endtask

  task wait_done();
    @(negedge clk);
    while (!done) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task run_frame(input int tx_base, input int rx_base, input int len, input logic traffic);
    int n;
    for (int i = 0; i < len; i++) begin
      img[i] = $random(seed);
      mem_write(ADDR_W'(tx_base + i), img[i]);
    end
    csr_write(eth_loop_pkg::CSR_TX_BASE, eth_loop_pkg::word_t'(tx_base));
    csr_write(eth_loop_pkg::CSR_RX_BASE, eth_loop_pkg::word_t'(rx_base));
    csr_write(eth_loop_pkg::CSR_LEN, eth_loop_pkg::word_t'(len));
    done_exp = 1'b1;
    csr_write(eth_loop_pkg::CSR_CTRL, 32'h1);
    done_exp = 1'b0;
    if (traffic) begin
      csr_read(eth_loop_pkg::CSR_STATUS, 32'h1);  // Busy, not done.
      csr_write(eth_loop_pkg::CSR_CTRL, 32'h1);   // Second start, must be dropped.
      for (int i = 0; i < EXT_WORDS; i++) begin
        mem_read(ADDR_W'(EXT_BASE + i), ext_words[i]);
      end
    end
    wait_done();
    n = ref_loopback(img, len, exp_rx);
    csr_read(eth_loop_pkg::CSR_STATUS, 32'h2);
    csr_read(eth_loop_pkg::CSR_RX_COUNT, eth_loop_pkg::word_t'(n));
    for (int i = 0; i < n; i++) begin
      mem_read(ADDR_W'(rx_base + i), exp_rx[i]);
    end
    csr_write(eth_loop_pkg::CSR_STATUS, 32'h0);   // Clears sticky done.
    csr_read(eth_loop_pkg::CSR_STATUS, 32'h0);
  endtask

  initial begin
    reset        = 1'b1;
    csr_valid    = 1'b0;
    csr_we       = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    mem_req      = 1'b0;
    mem_we       = 1'b0;
    mem_addr     = '0;
    mem_wdata    = '0;
    csr_exp_push = 1'b0;
    csr_exp      = '0;
    mem_exp_push = 1'b0;
    mem_exp      = '0;
    done_exp     = 1'b0;
    final_check  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int a = 0; a < 6; a++) begin
      csr_read(eth_loop_pkg::csr_addr_t'(a), '0);
    end
    csr_write(eth_loop_pkg::CSR_TX_BASE, 32'h5A);
    csr_write(eth_loop_pkg::CSR_RX_BASE, 32'hA5);
    csr_write(eth_loop_pkg::CSR_LEN, 32'h0C);
    csr_read(eth_loop_pkg::CSR_TX_BASE, 32'h5A);
    csr_read(eth_loop_pkg::CSR_RX_BASE, 32'hA5);
    csr_read(eth_loop_pkg::CSR_LEN, 32'h0C);
    for (int i = 0; i < EXT_WORDS; i++) begin
      ext_words[i] = $random(seed);
      mem_write(ADDR_W'(EXT_BASE + i), ext_words[i]);
    end
    for (int i = 0; i < EXT_WORDS; i++) begin
      mem_read(ADDR_W'(EXT_BASE + i), ext_words[i]);
    end
    run_frame('h00, 'h40, LEN_A, 1'b0);
    run_frame('h10, 'h50, LEN_B, 1'b0);          // Empty frame.
    run_frame('h20, 'h60, LEN_C, 1'b1);
    final_check = 1'b1;
    @(posedge clk);
    #1;
    final_check = 1'b0;
    @(posedge clk);
    #1;
    assert_errors = dut_i.arb_i.arb_chk_i.fail_count + dut_i.dma_tx_i.tx_chk_i.fail_count;
    $display("error counts: data %0d, assertions %0d", mon_errors, assert_errors);
    if ((mon_errors + assert_errors) == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- list.f
rtl/eth_loop_pkg.sv
rtl/word_ram.sv
rtl/mem_arbiter.sv
rtl/eth_csr.sv
rtl/eth_dma_tx.sv
rtl/eth_dma_rx.sv
rtl/eth_loop_top.sv
tb/eth_loop_checker.sv
tb/eth_loop_monitor.sv
tb/tb_eth_loop.sv

//--- Makefile
VERILATOR = verilator
TOP       = tb_eth_loop
FILELIST  = list.f
VFLAGS    = --timing --assert --timescale 1ns/100ps --top-module $(TOP)
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
